/* compile.f */
logic/cav_num_pkg.sv
logic/cav_cfg_pkg.sv
logic/iq_stream_if.sv
logic/cordic_rot.sv
logic/mode_couple_in.sv
logic/mode_resonator.sv
logic/mode_couple_out.sv
logic/cav_mode_top.sv
sim/cav_mode_chk.sv
sim/cav_mode_tb.sv

/* Bender.yml */
package:
  name: cav_mode

sources:
  # packages first, then interface and RTL
  - logic/cav_num_pkg.sv
  - logic/cav_cfg_pkg.sv
  - logic/iq_stream_if.sv
  - logic/cordic_rot.sv
  - logic/mode_couple_in.sv
  - logic/mode_resonator.sv
  - logic/mode_couple_out.sv
  - logic/cav_mode_top.sv
  - target: simulation
    files:
      - sim/cav_mode_chk.sv
      - sim/cav_mode_tb.sv

/* sim/cav_mode_tb.sv */
`timescale 1ns/1ps

module cav_mode_tb
	import cav_num_pkg::*;
	import cav_cfg_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 4;
	// IIR time constants waited before a row is checked
	localparam int TAU_COUNT = 12;
	// cycles sampled at the end of each row
	localparam int WINDOW = 16;
	localparam int NUM_ROWS = 7;
	localparam int RAND_SEED = 32'hc91e_c70a;

	// one stimulus row with its expected steady state
	typedef struct packed {
		sample_t drive;
		sample_t noise;
		sample_t drive_coupling;
		sample_t bw;
		logic signed [MECH_W-1:0] mech_freq;
		logic [BEAM_TIMING_W-1:0] beam_timing;
		sample_t beam_coupling;
		phase_t beam_phase;
		phase_t lo_step;
		sample_t out_couple;
		mag2_t exp_v2;
		mag2_t tol;
	} row_t;

	// drive 60000 * coupling 100000 / 2**17 = 45776, squared / 2**18 = 7993
	// beam 100000 * 2048 / 2**12 = 50000, squared / 2**18 = 9536
	// noise row, |48000 + j8000| * 100000 / 2**17 = 37126, squared / 2**18 = 5258
	localparam row_t ROWS [NUM_ROWS] = '{
		'{0, 0, 0, 16384, 0, 0, 0, 0, 0, 0, 0, 0},
		'{60000, 0, 100000, 16384, 0, 0, 0, 0, 0, 131071, 7993, 80},
		'{60000, 0, 100000, 16384, 1048576, 0, 0, 0, 0, 131071, 7993, 80},
		'{0, 0, 100000, 32768, 0, 2048, 100000, 19'h12345, 0, 131071, 9536, 96},
		'{0, 0, 100000, 32768, 0, 2048, 100000, 19'h5a000, 37, 131071, 9536, 96},
		'{60000, 0, 100000, 16384, 0, 0, 0, 0, 0, 131071, 7993, 80},
		'{40000, 8000, 100000, 16384, 1048576, 0, 0, 0, 53, 131071, 0, 5300}
	};

	logic clk;
	logic rst_n;
	logic iq;
	sample_t drive;
	logic [BEAM_TIMING_W-1:0] beam_timing;
	phase_t beam_phase;
	sample_t beam_coupling;
	sample_t drive_coupling;
	sample_t bw;
	logic signed [MECH_W-1:0] mech_freq;
	phase_t lo_phase;
	sample_t out_couple;
	out_t probe_refl;
	mag2_t v_squared;

	row_t cur;
	int n_checks;
	int err_mag2;
	int err_out;

	cav_mode_top DUT (
		.clk(clk),
		.rst_n(rst_n),
		.iq(iq),
		.drive(drive),
		.beam_timing(beam_timing),
		.beam_phase(beam_phase),
		.beam_coupling(beam_coupling),
		.drive_coupling(drive_coupling),
		.bw(bw),
		.mech_freq(mech_freq),
		.lo_phase(lo_phase),
		.out_couple(out_couple),
		.probe_refl(probe_refl),
		.v_squared(v_squared)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// one pair every two cycles, time constant 2**IIR_SHIFT / bw pairs
	function automatic int settle_cycles(input sample_t bw_val);
		return 2 * TAU_COUNT * (1 << IIR_SHIFT) / int'(bw_val)
			+ LAT_IN + LAT_RES + LAT_OUT + 8;
	endfunction

	// uniform noise in [-amp, amp]
	function automatic int noise_val(input sample_t amp);
		int span;
		if (amp == 0)
			return 0;
		span = 2 * int'(amp) + 1;
		return int'($urandom % span) - int'(amp);
	endfunction

	// probe pair power referred back to the v_squared scale
	function automatic mag2_t pair_mag2(input out_t a, input out_t b, input sample_t couple);
		real gain;
		real m;
		gain = real'(couple) / 2.0 ** OUT_SHIFT;
		m = (real'(a) * real'(a) + real'(b) * real'(b)) / (gain * gain);
		m = m / 2.0 ** MAG2_SHIFT;
		if (m > real'(MAG2_MAX))
			m = real'(MAG2_MAX);
		return mag2_t'($rtoi(m + 0.5));
	endfunction

	task automatic check_mag2(input string name, input mag2_t got, input mag2_t want,
		input mag2_t tol);
		longint diff;
		diff = longint'(got) - longint'(want);
		if (diff < 0)
			diff = -diff;
		n_checks++;
		if (diff > longint'(tol)) begin
			err_mag2++;
			$display("Error at %0t: %s got %0d, expected %0d (tolerance %0d)",
				$time, name, got, want, tol);
		end
	endtask

	task automatic check_out(input string name, input out_t got, input out_t want,
		input out_t tol);
		longint diff;
		diff = longint'(got) - longint'(want);
		if (diff < 0)
			diff = -diff;
		n_checks++;
		if (diff > longint'(tol)) begin
			err_out++;
			$display("Error at %0t: %s got %0d, expected %0d (tolerance %0d)",
				$time, name, got, want, tol);
		end
	endtask

	// advance one half-sample, inputs change 1 ns after the edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
		iq = ~iq;
		if (iq) begin
			drive = sample_t'(int'(cur.drive) + noise_val(cur.noise));
			// lo moves once per pair
			lo_phase = lo_phase + cur.lo_step;
		end else begin
			drive = sample_t'(noise_val(cur.noise));
		end
	endtask

	task automatic apply_row(input row_t r);
		cur = r;
		drive_coupling = r.drive_coupling;
		bw = r.bw;
		mech_freq = r.mech_freq;
		beam_timing = r.beam_timing;
		beam_coupling = r.beam_coupling;
		beam_phase = r.beam_phase;
		out_couple = r.out_couple;
	endtask

	task automatic check_row(input row_t r);
		out_t prev;
		out_t pbound;
		real fmax;
		int k;
		// largest field allowed by the v_squared bound, scaled by the coupling
		fmax = $sqrt(real'(r.tol) * 2.0 ** MAG2_SHIFT);
		pbound = out_t'($rtoi(real'(r.out_couple) * fmax / 2.0 ** OUT_SHIFT) + 8);
		prev = probe_refl;
		for (k = 0; k < WINDOW; k++) begin
			next_cycle();
			check_mag2("v_squared", v_squared, r.exp_v2, r.tol);
			if (r.noise != 0)
				check_out("probe_refl", probe_refl, '0, pbound);
			else if (r.out_couple == 0)
				check_out("probe_refl", probe_refl, '0, '0);
			else
				// any two neighbours form one re/im pair once settled
				check_mag2("probe_refl pair", pair_mag2(prev, probe_refl, r.out_couple),
					r.exp_v2, r.tol);
			prev = probe_refl;
		end
	endtask

	task automatic print_counts();
		$display("checks %0d, v_squared errors %0d, probe_refl errors %0d, assertion failures %0d",
			n_checks, err_mag2, err_out, DUT.u_chk.fail_count);
	endtask

	initial begin
		int i;
		void'($urandom(RAND_SEED));
		n_checks = 0;
		err_mag2 = 0;
		err_out = 0;
		cur = '0;
		iq = 1'b0;
		drive = '0;
		beam_timing = '0;
		beam_phase = '0;
		beam_coupling = '0;
		drive_coupling = '0;
		bw = '0;
		mech_freq = '0;
		lo_phase = '0;
		out_couple = '0;
		rst_n = 1'b1;
		#1;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (i = 0; i < NUM_ROWS; i++) begin
			apply_row(ROWS[i]);
			repeat (settle_cycles(ROWS[i].bw)) next_cycle();
			check_row(ROWS[i]);
		end
		print_counts();
		if (err_mag2 + err_out + DUT.u_chk.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// run length follows from the row table
	initial begin
		longint limit;
		int r;
		limit = RESET_CYCLES + 100;
		for (r = 0; r < NUM_ROWS; r++)
			limit = limit + settle_cycles(ROWS[r].bw) + WINDOW + 1;
		#(limit * CLK_PERIOD);
		$display("Timeout: the row sequence did not finish within %0d cycles", limit);
		print_counts();
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* sim/cav_mode_chk.sv */
`timescale 1ns/1ps

module cav_mode_chk
	import cav_num_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input out_t probe_refl,
	input mag2_t v_squared
);

	int fail_count = 0;

	// outputs held at zero while reset is low
	a_reset_zero: assert property (@(posedge clk)
		!rst_n |-> (probe_refl == '0 && v_squared == '0))
		else begin
			$error("probe_refl or v_squared nonzero during reset");
			fail_count++;
		end

	// squared magnitude keeps its msb clear
	a_mag2_pos: assert property (@(posedge clk) disable iff (!rst_n)
		v_squared <= MAG2_MAX)
		else begin
			$error("v_squared has its sign bit set");
			fail_count++;
		end

	// rotated field times a coupling stays inside the symmetric output range
	a_out_range: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(probe_refl) && probe_refl >= -OUT_MAX)
		else begin
			$error("probe_refl unknown or outside the output range");
			fail_count++;
		end

endmodule

bind cav_mode_top cav_mode_chk u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.probe_refl(probe_refl),
	.v_squared(v_squared)
);

/* logic/cav_mode_top.sv */
`timescale 1ns/1ps

module cav_mode_top
	import cav_num_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic iq,
	input sample_t drive,
	input logic [BEAM_TIMING_W-1:0] beam_timing,
	input phase_t beam_phase,
	input sample_t beam_coupling,
	input sample_t drive_coupling,
	input sample_t bw,
	input logic signed [MECH_W-1:0] mech_freq,
	input phase_t lo_phase,
	input sample_t out_couple,
	output out_t probe_refl,
	output mag2_t v_squared
);

	// coupler to resonator, resonator to output coupler
	iq_stream_if s_cav ();
	iq_stream_if s_fld ();
	phase_t mech_phase;

	mode_couple_in u_couple_in (
		.clk(clk),
		.rst_n(rst_n),
		.iq(iq),
		.drive(drive),
		.beam_timing(beam_timing),
		.beam_phase(beam_phase),
		.beam_coupling(beam_coupling),
		.drive_coupling(drive_coupling),
		.mech_freq(mech_freq),
		.mech_phase(mech_phase),
		.s_cav(s_cav)
	);

	mode_resonator u_resonator (
		.clk(clk),
		.rst_n(rst_n),
		.s_cav(s_cav),
		.bw(bw),
		.s_fld(s_fld),
		.v_squared(v_squared)
	);

	mode_couple_out u_couple_out (
		.clk(clk),
		.rst_n(rst_n),
		.s_fld(s_fld),
		.lo_phase(lo_phase),
		.mech_phase(mech_phase),
		.out_couple(out_couple),
		.probe_refl(probe_refl)
	);

endmodule

/* logic/mode_couple_out.sv */
`timescale 1ns/1ps

module mode_couple_out
	import cav_num_pkg::*;
	import cav_cfg_pkg::*;
(
	input logic clk,
	input logic rst_n,
	iq_stream_if.dst s_fld,
	input phase_t lo_phase,
	input phase_t mech_phase,
	input sample_t out_couple,
	output out_t probe_refl
);

	phase_t out_phase;
	out_tag_t tag_in, tag_out;
	sample_t rot_re, rot_im, part;
	logic signed [2*SAMPLE_W-1:0] scaled;

	// IF phase relative to the cavity frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_phase <= '0;
		else
			out_phase <= lo_phase - mech_phase;
	end

	// field is held over the whole pair
	// the Q-strobe cycle yields the real part, the next one the imaginary
	assign tag_in = '{re_sel: ~s_fld.iq, couple: out_couple};

	cordic_rot #(
		.tag_t(out_tag_t)
	) u_cordic (
		.clk(clk),
		.rst_n(rst_n),
		.x_in(s_fld.re),
		.y_in(s_fld.im),
		.phase_in(out_phase),
		.tag_in(tag_in),
		.x_out(rot_re),
		.y_out(rot_im),
		.tag_out(tag_out)
	);

	assign part = tag_out.re_sel ? rot_re : rot_im;
	// coupling travelled with the sample, so it matches this rotation
	assign scaled = part * tag_out.couple;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			probe_refl <= '0;
		else
			probe_refl <= sat_out(scaled >>> OUT_SHIFT);
	end

endmodule

/* logic/mode_resonator.sv */
`timescale 1ns/1ps

module mode_resonator
	import cav_num_pkg::*;
	import cav_cfg_pkg::*;
(
	input logic clk,
	input logic rst_n,
	iq_stream_if.dst s_cav,
	input sample_t bw,
	iq_stream_if.src s_fld,
	output mag2_t v_squared
);

	sample_t beam_re;
	logic signed [SAMPLE_W:0] u_re, u_im, u_im_q;
	logic signed [SAMPLE_W:0] st_re_hi, st_im_hi;
	logic signed [SAMPLE_W+1:0] diff;
	logic signed [RES_W-1:0] st_re, st_im, prod;
	sample_t fld_re_n, fld_im_n;
	logic [2*SAMPLE_W:0] mag2_sum;
	logic [LAT_RES-1:0] iq_d;

	// total excitation, drive plus beam
	assign u_re = s_cav.re + beam_re;
	assign u_im = s_cav.im + s_cav.aux;

	// state keeps IIR_SHIFT fraction bits
	assign st_re_hi = st_re[IIR_SHIFT +: SAMPLE_W+1];
	assign st_im_hi = st_im[IIR_SHIFT +: SAMPLE_W+1];

	// one multiplier, I error on I cycles, Q error on Q cycles
	assign prod = bw * diff;

	assign fld_re_n = sat_sample(st_re_hi);
	assign fld_im_n = sat_sample(st_im_hi);
	assign mag2_sum = fld_re_n * fld_re_n + fld_im_n * fld_im_n;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beam_re <= '0;
			u_im_q <= '0;
			diff <= '0;
			st_re <= '0;
			st_im <= '0;
			iq_d <= '0;
			s_fld.re <= '0;
			s_fld.im <= '0;
			v_squared <= '0;
		end else begin
			iq_d <= {iq_d[LAT_RES-2:0], s_cav.iq};
			if (s_cav.iq) begin
				// real half of the beam vector arrives first
				beam_re <= s_cav.aux;
				// apply I error from the previous Q cycle
				st_re <= st_re + prod;
				diff <= u_im_q - st_im_hi;
				// both parts now hold the previous pair
				s_fld.re <= fld_re_n;
				s_fld.im <= fld_im_n;
				if (mag2_sum[2*SAMPLE_W:MAG2_SHIFT] > MAG2_MAX)
					v_squared <= MAG2_MAX;
				else
					v_squared <= mag2_t'(mag2_sum >> MAG2_SHIFT);
			end else begin
				// pair complete, queue Q and start on I
				st_im <= st_im + prod;
				u_im_q <= u_im;
				diff <= u_re - st_re_hi;
			end
		end
	end

	assign s_fld.iq = iq_d[LAT_RES-1];
	// no beam term past the resonator
	assign s_fld.aux = '0;

endmodule

/* logic/mode_couple_in.sv */
`timescale 1ns/1ps

module mode_couple_in
	import cav_num_pkg::*;
	import cav_cfg_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic iq,
	input sample_t drive,
	input logic [BEAM_TIMING_W-1:0] beam_timing,
	input phase_t beam_phase,
	input sample_t beam_coupling,
	input sample_t drive_coupling,
	input logic signed [MECH_W-1:0] mech_freq,
	output phase_t mech_phase,
	iq_stream_if.src s_cav
);

	logic [MECH_ACC_W-1:0] mech_acc;
	logic signed [SAMPLE_W+BEAM_TIMING_W:0] beam_prod;
	sample_t beam_mag;
	sample_t rot_x, rot_xo, rot_yo;
	phase_t rot_phase;
	in_tag_t rot_tag, rot_tago;
	cplx_t coef, beam_vec;
	sample_t drive_i;
	logic signed [2*SAMPLE_W:0] mul_re, mul_im;

	// mechanical phase advances once per pair
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mech_acc <= '0;
		else if (!iq)
			mech_acc <= mech_acc + {{(MECH_ACC_W-MECH_W){mech_freq[MECH_W-1]}}, mech_freq};
	end

	assign mech_phase = mech_acc[MECH_ACC_W-1 -: PHASE_W];

	// beam magnitude, timing treated as unsigned fraction of full scale
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			beam_prod <= '0;
		else
			beam_prod <= beam_coupling * $signed({1'b0, beam_timing});
	end

	assign beam_mag = beam_prod[BEAM_TIMING_W +: SAMPLE_W];

	// rotator alternates jobs
	// I cycles load the beam job, Q cycles the drive coupling
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rot_x <= '0;
			rot_phase <= '0;
			rot_tag <= '0;
		end else begin
			rot_x <= iq ? beam_mag : drive_coupling;
			rot_phase <= iq ? mech_phase + beam_phase : mech_phase;
			rot_tag.beam <= iq;
		end
	end

	cordic_rot #(
		.tag_t(in_tag_t)
	) u_cordic (
		.clk(clk),
		.rst_n(rst_n),
		.x_in(rot_x),
		.y_in(SAMPLE_W'(0)),
		.phase_in(rot_phase),
		.tag_in(rot_tag),
		.x_out(rot_xo),
		.y_out(rot_yo),
		.tag_out(rot_tago)
	);

	// sort rotator results by job
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			coef <= '0;
			beam_vec <= '0;
		end else if (rot_tago.beam) begin
			beam_vec <= '{re: rot_xo, im: rot_yo};
		end else begin
			coef <= '{re: rot_xo, im: rot_yo};
		end
	end

	// complex multiply drive by the coupling vector
	// real half held from the I cycle, both parts formed on Q
	assign mul_re = drive_i * coef.re - drive * coef.im;
	assign mul_im = drive_i * coef.im + drive * coef.re;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive_i <= '0;
			s_cav.iq <= 1'b0;
			s_cav.re <= '0;
			s_cav.im <= '0;
			s_cav.aux <= '0;
		end else begin
			s_cav.iq <= iq;
			// beam vector goes out interleaved
			s_cav.aux <= iq ? beam_vec.re : beam_vec.im;
			if (iq) begin
				drive_i <= drive;
			end else begin
				s_cav.re <= sat_sample(mul_re >>> (SAMPLE_W - 1));
				s_cav.im <= sat_sample(mul_im >>> (SAMPLE_W - 1));
			end
		end
	end

endmodule

/* logic/cordic_rot.sv */
`timescale 1ns/1ps

module cordic_rot
	import cav_num_pkg::*;
	import cav_cfg_pkg::*;
#(
	parameter type tag_t = logic
) (
	input logic clk,
	input logic rst_n,
	input sample_t x_in,
	input sample_t y_in,
	input phase_t phase_in,
	input tag_t tag_in,
	output sample_t x_out,
	output sample_t y_out,
	output tag_t tag_out
);

	typedef logic signed [CORDIC_XW-1:0] xw_t;
	typedef logic signed [CORDIC_ZW-1:0] zw_t;

	xw_t x_ext, y_ext, x_pre, y_pre;
	zw_t z_pre;
	xw_t x_q [CORDIC_STAGES];
	xw_t y_q [CORDIC_STAGES];
	zw_t z_q [CORDIC_STAGES];
	tag_t tag_q [CORDIC_STAGES];
	logic signed [CORDIC_XW+SAMPLE_W-1:0] x_gain, y_gain;

	// widen with guard bits below the lsb
	assign x_ext = xw_t'(x_in) <<< CORDIC_FRAC;
	assign y_ext = xw_t'(y_in) <<< CORDIC_FRAC;

	// coarse rotation by the top two phase bits
	// leaves a residual angle in [0, 90) degrees
	always_comb begin
		unique case (phase_in[PHASE_W-1 -: 2])
			2'd0: begin
				x_pre = x_ext;
				y_pre = y_ext;
			end
			2'd1: begin
				x_pre = -y_ext;
				y_pre = x_ext;
			end
			2'd2: begin
				x_pre = -x_ext;
				y_pre = -y_ext;
			end
			default: begin
				x_pre = y_ext;
				y_pre = -x_ext;
			end
		endcase
		z_pre = zw_t'({phase_in[PHASE_W-3:0], {CORDIC_FRAC{1'b0}}});
	end

	// shift-add iterations, drive the residual angle to zero
	for (genvar i = 0; i < CORDIC_STAGES; i++) begin : g_iter
		xw_t x_i, y_i;
		zw_t z_i;
		tag_t tag_i;

		if (i == 0) begin : g_first
			assign x_i = x_pre;
			assign y_i = y_pre;
			assign z_i = z_pre;
			assign tag_i = tag_in;
		end else begin : g_next
			assign x_i = x_q[i-1];
			assign y_i = y_q[i-1];
			assign z_i = z_q[i-1];
			assign tag_i = tag_q[i-1];
		end

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				x_q[i] <= '0;
				y_q[i] <= '0;
				z_q[i] <= '0;
				tag_q[i] <= '0;
			end else begin
				// negative residual, rotate clockwise
				if (z_i[CORDIC_ZW-1]) begin
					x_q[i] <= x_i + (y_i >>> i);
					y_q[i] <= y_i - (x_i >>> i);
					z_q[i] <= z_i + CORDIC_ATAN[i];
				end else begin
					x_q[i] <= x_i - (y_i >>> i);
					y_q[i] <= y_i + (x_i >>> i);
					z_q[i] <= z_i - CORDIC_ATAN[i];
				end
				tag_q[i] <= tag_i;
			end
		end
	end

	// remove the CORDIC gain, drop guard bits
	assign x_gain = x_q[CORDIC_STAGES-1] * CORDIC_INV_GAIN;
	assign y_gain = y_q[CORDIC_STAGES-1] * CORDIC_INV_GAIN;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_out <= '0;
			y_out <= '0;
			tag_out <= '0;
		end else begin
			x_out <= sat_sample(x_gain >>> (SAMPLE_W - 1 + CORDIC_FRAC));
			y_out <= sat_sample(y_gain >>> (SAMPLE_W - 1 + CORDIC_FRAC));
			tag_out <= tag_q[CORDIC_STAGES-1];
		end
	end

endmodule

/* logic/iq_stream_if.sv */
`timescale 1ns/1ps

interface iq_stream_if
	import cav_num_pkg::*;
();

	// strobe, high on I half, low on Q half
	logic iq;
	// complex value of the current pair
	// both parts valid while iq is low
	sample_t re;
	sample_t im;
	// beam vector between coupler and resonator
	// real part with iq high, imaginary with iq low
	sample_t aux;

	modport src (
		output iq,
		output re,
		output im,
		output aux
	);

	modport dst (
		input iq,
		input re,
		input im,
		input aux
	);

endinterface

/* logic/cav_cfg_pkg.sv */
package cav_cfg_pkg;

	import cav_num_pkg::*;

	// rotator iterations, one register each
	localparam int CORDIC_STAGES = 18;
	// guard bits below the lsb, for both x/y and angle
	localparam int CORDIC_FRAC = 2;
	localparam int CORDIC_XW = SAMPLE_W + 4;
	localparam int CORDIC_ZW = PHASE_W + 3;
	// 1/K for 18 iterations, Q17
	localparam sample_t CORDIC_INV_GAIN = 18'sd79594;
	// atan(2**-i), 2**21 units per turn
	localparam logic signed [CORDIC_ZW-1:0] CORDIC_ATAN [CORDIC_STAGES] = '{
		262144, 154753, 81767, 41506, 20834, 10427,
		5215, 2608, 1304, 652, 326, 163,
		81, 41, 20, 10, 5, 3
	};

	// resonator bandwidth scaling and state width
	localparam int IIR_SHIFT = 18;
	localparam int RES_W = SAMPLE_W + IIR_SHIFT + 3;
	// squared magnitude scaled back to 17 significant bits
	localparam int MAG2_SHIFT = 18;
	// probe/reflected scaling after the output coupling multiply
	localparam int OUT_SHIFT = 16;

	// cycles from pair valid at a stage input to pair valid at its output
	localparam int LAT_IN = 1;
	localparam int LAT_RES = 4;
	localparam int LAT_OUT = CORDIC_STAGES + 2;

	// input rotator job, beam vector or drive coefficient
	typedef struct packed {
		logic beam;
	} in_tag_t;

	// output rotator carries its coupling and which part to emit
	typedef struct packed {
		logic re_sel;
		sample_t couple;
	} out_tag_t;

endpackage

/* logic/cav_num_pkg.sv */
package cav_num_pkg;

	// sample width shared by drive, field and couplings
	localparam int SAMPLE_W = 18;
	// phase words, one full turn is 2**PHASE_W
	localparam int PHASE_W = 19;
	// signed mechanical frequency step
	localparam int MECH_W = 28;
	// mechanical phase accumulator, top PHASE_W bits give the phase
	localparam int MECH_ACC_W = 32;
	localparam int BEAM_TIMING_W = 12;
	// probe/reflected output carries one extra bit
	localparam int OUT_W = SAMPLE_W + 1;
	// width of intermediate products handed to the saturators
	localparam int WIDE_W = 48;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic [PHASE_W-1:0] phase_t;
	typedef logic [SAMPLE_W-1:0] mag2_t;
	typedef logic signed [OUT_W-1:0] out_t;

	// one complex value, real part in the upper half
	typedef struct packed {
		sample_t re;
		sample_t im;
	} cplx_t;

	localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_W-1){1'b0}}};
	localparam out_t OUT_MAX = {1'b0, {(OUT_W-1){1'b1}}};
	localparam out_t OUT_MIN = {1'b1, {(OUT_W-1){1'b0}}};
	// squared magnitude keeps its msb clear
	localparam mag2_t MAG2_MAX = {1'b0, {(SAMPLE_W-1){1'b1}}};

	// clamp a wide signed value into the sample range
	function automatic sample_t sat_sample(input logic signed [WIDE_W-1:0] v);
		if (v > SAMPLE_MAX)
			return SAMPLE_MAX;
		else if (v < SAMPLE_MIN)
			return SAMPLE_MIN;
		return v[SAMPLE_W-1:0];
	endfunction

	// same clamp for the wider output sample
	function automatic out_t sat_out(input logic signed [WIDE_W-1:0] v);
		if (v > OUT_MAX)
			return OUT_MAX;
		else if (v < OUT_MIN)
			return OUT_MIN;
		return v[OUT_W-1:0];
	endfunction

endpackage
